// ==== Bender.yml ====
package:
  name: sprite_engine

sources:
  - files:
      - src/video_pkg.sv
      - src/sprite_pkg.sv
      - src/dual_port_ram.sv
      - src/sprite_attr_regs.sv
      - src/scanline_buffer.sv
      - src/sprite_renderer.sv
      - src/sprite_engine_top.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/sprite_engine_tb.sv

// ==== src/dual_port_ram.sv ====
// Simple dual-port block RAM with one read and one write port.
// Read data is registered. Reading the address being written returns
// an unspecified value, so callers must not depend on it.
// Contents are not reset.
`timescale 1ns/10ps

module dual_port_ram #(
	parameter int BITS = 16,
	parameter int ADDRESS_BITS = 8
) (
	input  logic CLK,
	input  logic [ADDRESS_BITS-1:0] rd_addr,
	output logic [BITS-1:0] rd_data,
	input  logic [ADDRESS_BITS-1:0] wr_addr,
	input  logic [BITS-1:0] wr_data,
	input  logic wr
);

	logic [BITS-1:0] mem [0:(1 << ADDRESS_BITS) - 1];

	always_ff @(posedge CLK) begin
		if (wr) begin
			mem[wr_addr] <= wr_data;
		end
		rd_data <= mem[rd_addr];
	end

endmodule

// ==== src/scanline_buffer.sv ====
// Double line buffer. The renderer writes the back half while the display
// reads the front half. H_tick swaps the halves and must coincide with display_x 0.
// Read latency is one clock. The front half is zeroed one pixel behind the read.
// Render writes at X of 800 or more are dropped.
`timescale 1ns/10ps

module scanline_buffer (
	input  logic CLK,
	input  logic RSTb,
	input  logic H_tick,
	input  logic [video_pkg::COORD_BITS-1:0] display_x,
	output logic [video_pkg::PIXEL_BITS-1:0] color_index,
	input  logic pix_wr,
	input  logic [video_pkg::COORD_BITS-1:0] pix_x,
	input  logic [video_pkg::PIXEL_BITS-1:0] pix_color
);

	import video_pkg::*;

	// Half currently being rendered
	logic active;
	logic render_ok;
	logic [COORD_BITS-1:0] clear_x;
	logic [1:0] render_hit;
	logic [1:0] clear_hit;
	logic [1:0] ram_wr;
	logic [COORD_BITS-1:0] wr_addr [2];
	logic [PIXEL_BITS-1:0] wr_data [2];
	logic [PIXEL_BITS-1:0] rd_data [2];

	assign render_ok = pix_wr && (pix_x < COORD_BITS'(LINE_PIXELS));

	// Position read on the previous clock
	assign clear_x = (display_x == '0) ? COORD_BITS'(LINE_PIXELS - 1) : display_x - 1'b1;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			active <= 1'b0;
		end else if (H_tick) begin
			active <= ~active;
		end
	end

	for (genvar j = 0; j < 2; j++) begin : g_half
		assign render_hit[j] = render_ok && (active == 1'(j));
		assign clear_hit[j]  = (active != 1'(j));
		assign ram_wr[j]     = render_hit[j] || clear_hit[j];
		assign wr_addr[j]    = clear_hit[j] ? clear_x : pix_x;
		assign wr_data[j]    = clear_hit[j] ? '0 : pix_color;

		// Both halves read display_x; the output mux picks the front one
		dual_port_ram #(
			.BITS(PIXEL_BITS),
			.ADDRESS_BITS(COORD_BITS)
		) i_ram (
			.CLK(CLK),
			.rd_addr(display_x),
			.rd_data(rd_data[j]),
			.wr_addr(wr_addr[j]),
			.wr_data(wr_data[j]),
			.wr(ram_wr[j])
		);
	end

	// Select is taken after the swap, so pixel 0 of a new line comes from the new front
	assign color_index = rd_data[~active];

	// Swap only at the first pixel, so the clear of pixel 799 lands in the old front
	a_tick_at_line_start: assert property (@(posedge CLK) disable iff (!RSTb)
		H_tick |-> display_x == '0);

endmodule

// ==== src/sprite_attr_regs.sv ====
// Sprite attribute store with four banks: X, Y, end row and sheet address.
// Host writes only. The banks cannot be read back over the host port.
// All four banks share the read index, so a full attribute set
// arrives one clock after sprite_index.
`timescale 1ns/10ps

module sprite_attr_regs (
	input  logic CLK,
	input  logic [9:0] ADDRESS,
	input  logic [sprite_pkg::ATTR_BITS-1:0] DATA_IN,
	input  logic WR,
	input  logic [sprite_pkg::SPRITE_IDX_BITS-1:0] sprite_index,
	output logic [sprite_pkg::ATTR_BITS-1:0] x_attr,
	output logic [sprite_pkg::ATTR_BITS-1:0] y_attr,
	output logic [sprite_pkg::ATTR_BITS-1:0] end_attr,
	output logic [sprite_pkg::ATTR_BITS-1:0] addr_attr
);

	import sprite_pkg::*;

	logic [1:0] bank_sel;
	logic [3:0] bank_wr;
	logic [ATTR_BITS-1:0] bank_data [4];

	assign bank_sel = ADDRESS[9:8];

	// Steer the host strobe to the addressed bank
	always_comb begin
		bank_wr = 4'b0000;
		case (bank_sel)
			BANK_X:    bank_wr[BANK_X] = WR;
			BANK_Y:    bank_wr[BANK_Y] = WR;
			BANK_END:  bank_wr[BANK_END] = WR;
			BANK_ADDR: bank_wr[BANK_ADDR] = WR;
			default: ;
		endcase
	end

	for (genvar b = 0; b < 4; b++) begin : g_bank
		dual_port_ram #(
			.BITS(ATTR_BITS),
			.ADDRESS_BITS(SPRITE_IDX_BITS)
		) i_ram (
			.CLK(CLK),
			.rd_addr(sprite_index),
			.rd_data(bank_data[b]),
			.wr_addr(ADDRESS[SPRITE_IDX_BITS-1:0]),
			.wr_data(DATA_IN),
			.wr(bank_wr[b])
		);
	end

	assign x_attr    = bank_data[BANK_X];
	assign y_attr    = bank_data[BANK_Y];
	assign end_attr  = bank_data[BANK_END];
	assign addr_attr = bank_data[BANK_ADDR];

endmodule

// ==== src/sprite_engine_top.sv ====
// Sprite engine: attribute banks, line renderer and double line buffer.
// A line rendered while display_y is N is shown during the next line,
// one clock behind display_x. H_tick must pulse at display_x 0.
`timescale 1ns/10ps

module sprite_engine_top (
	input  logic CLK,
	input  logic RSTb,
	input  logic [9:0] ADDRESS,
	input  logic [15:0] DATA_IN,
	input  logic WR,
	input  logic H_tick,
	input  logic [video_pkg::COORD_BITS-1:0] display_x,
	input  logic [video_pkg::COORD_BITS-1:0] display_y,
	output logic [video_pkg::PIXEL_BITS-1:0] color_index,
	output logic [15:0] memory_address,
	input  logic [15:0] memory_data,
	output logic rvalid,
	input  logic rready
);

	import video_pkg::*;

	logic [7:0] sprite_index;
	logic [15:0] x_attr;
	logic [15:0] y_attr;
	logic [15:0] end_attr;
	logic [15:0] addr_attr;

	// Renderer to line buffer
	logic pix_wr;
	logic [COORD_BITS-1:0] pix_x;
	logic [PIXEL_BITS-1:0] pix_color;

	sprite_attr_regs i_attr (
		.CLK(CLK),
		.ADDRESS(ADDRESS),
		.DATA_IN(DATA_IN),
		.WR(WR),
		.sprite_index(sprite_index),
		.x_attr(x_attr),
		.y_attr(y_attr),
		.end_attr(end_attr),
		.addr_attr(addr_attr)
	);

	sprite_renderer i_renderer (
		.CLK(CLK),
		.RSTb(RSTb),
		.H_tick(H_tick),
		.display_y(display_y),
		.sprite_index(sprite_index),
		.x_attr(x_attr),
		.y_attr(y_attr),
		.end_attr(end_attr),
		.addr_attr(addr_attr),
		.memory_address(memory_address),
		.memory_data(memory_data),
		.rvalid(rvalid),
		.rready(rready),
		.pix_wr(pix_wr),
		.pix_x(pix_x),
		.pix_color(pix_color)
	);

	scanline_buffer i_line_buf (
		.CLK(CLK),
		.RSTb(RSTb),
		.H_tick(H_tick),
		.display_x(display_x),
		.color_index(color_index),
		.pix_wr(pix_wr),
		.pix_x(pix_x),
		.pix_color(pix_color)
	);

endmodule

// ==== src/sprite_pkg.sv ====
// Sprite attribute layout, host bank codes, sheet strides and renderer states.
// Sheet addresses are in 16-bit words; nibble addresses are four times wider.
package sprite_pkg;

	localparam int SPRITE_COUNT    = 256;
	localparam int SPRITE_IDX_BITS = 8;
	localparam int ATTR_BITS       = 16;

	// Host address bits 9:8 pick one of these banks
	localparam logic [1:0] BANK_X    = 2'd0;
	localparam logic [1:0] BANK_Y    = 2'd1;
	localparam logic [1:0] BANK_END  = 2'd2;
	localparam logic [1:0] BANK_ADDR = 2'd3;

	// X word: position, enable, palette, stride select
	localparam int X_POS_LSB    = 0;
	localparam int X_POS_BITS   = 10;
	localparam int X_ENABLE_BIT = 10;
	localparam int X_PAL_LSB    = 11;
	localparam int X_PAL_BITS   = 4;
	localparam int X_STRIDE_BIT = 15;

	// Y word: start row and width; width holds pixel count minus one
	localparam int Y_POS_LSB    = 0;
	localparam int Y_POS_BITS   = 10;
	localparam int Y_WIDTH_LSB  = 10;
	localparam int Y_WIDTH_BITS = 6;

	// End word: last row the sprite covers
	localparam int END_ROW_LSB  = 0;
	localparam int END_ROW_BITS = 10;

	// Sheet row pitch in nibbles
	localparam int STRIDE_NARROW = 128;
	localparam int STRIDE_WIDE   = 256;

	localparam int NIBBLE_BITS     = 4;
	localparam int SHEET_ADDR_BITS = ATTR_BITS + 2;

	typedef enum logic [3:0] {
		R_IDLE,
		R_BEGIN,
		R_LOAD_REGS,
		R_LOAD_ADDR,
		R_REQ,
		R_WAIT,
		R_BLIT,
		R_NEXT
	} render_state_t;

endpackage

// ==== src/sprite_renderer.sv ====
// Per-line sprite walk. On H_tick all 256 sprites are visited in index order
// and visible rows are drawn into the back line buffer.
// Width is at most 64 pixels. A line must finish before the next H_tick,
// or the remaining sprites are skipped.
// Memory requests hold rvalid and memory_address until rready.
`timescale 1ns/10ps

module sprite_renderer (
	input  logic CLK,
	input  logic RSTb,
	input  logic H_tick,
	input  logic [video_pkg::COORD_BITS-1:0] display_y,
	output logic [sprite_pkg::SPRITE_IDX_BITS-1:0] sprite_index,
	input  logic [sprite_pkg::ATTR_BITS-1:0] x_attr,
	input  logic [sprite_pkg::ATTR_BITS-1:0] y_attr,
	input  logic [sprite_pkg::ATTR_BITS-1:0] end_attr,
	input  logic [sprite_pkg::ATTR_BITS-1:0] addr_attr,
	output logic [15:0] memory_address,
	input  logic [15:0] memory_data,
	output logic rvalid,
	input  logic rready,
	output logic pix_wr,
	output logic [video_pkg::COORD_BITS-1:0] pix_x,
	output logic [video_pkg::PIXEL_BITS-1:0] pix_color
);

	import sprite_pkg::*;
	import video_pkg::*;

	render_state_t state;
	logic [SPRITE_IDX_BITS-1:0] index;

	// Latched per sprite
	// cur_x has a spare top bit so pixels past 1023 do not wrap onto the line
	logic [COORD_BITS:0] cur_x;
	logic [COORD_BITS-1:0] row;
	logic [X_PAL_BITS-1:0] palette;
	logic [Y_WIDTH_BITS-1:0] width;
	logic [Y_WIDTH_BITS-1:0] count;
	logic wide;
	logic [ATTR_BITS-1:0] sheet_base;

	logic [SHEET_ADDR_BITS-1:0] row_offset;
	logic [SHEET_ADDR_BITS-1:0] nib_addr;
	logic [15:0] sheet_word;
	logic [NIBBLE_BITS-1:0] nibble;
	logic [COORD_BITS-1:0] y_start;
	logic visible;

	assign sprite_index   = index;
	assign memory_address = nib_addr[SHEET_ADDR_BITS-1:2];

	assign y_start = y_attr[Y_POS_LSB +: Y_POS_BITS];

	// Enabled and display_y within start..end rows
	assign visible = x_attr[X_ENABLE_BIT] && (display_y >= y_start) &&
		(display_y <= end_attr[END_ROW_LSB +: END_ROW_BITS]);

	assign row_offset = wide ? SHEET_ADDR_BITS'(row * STRIDE_WIDE) :
		SHEET_ADDR_BITS'(row * STRIDE_NARROW);

	// Low nibble first within each fetched word
	assign nibble = sheet_word[count[1:0] * NIBBLE_BITS +: NIBBLE_BITS];

	// Control
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= R_IDLE;
			index <= '0;
			rvalid <= 1'b0;
			pix_wr <= 1'b0;
		end else if (H_tick) begin
			// New line: drop whatever was in flight
			state <= R_BEGIN;
			index <= '0;
			rvalid <= 1'b0;
			pix_wr <= 1'b0;
		end else begin
			pix_wr <= 1'b0;
			case (state)
				R_IDLE: ;
				R_BEGIN: begin
					// Attribute RAMs read sprite_index this cycle
					state <= R_LOAD_REGS;
				end
				R_LOAD_REGS: begin
					state <= visible ? R_LOAD_ADDR : R_NEXT;
				end
				R_LOAD_ADDR: begin
					state <= R_REQ;
				end
				R_REQ: begin
					rvalid <= 1'b1;
					state <= R_WAIT;
				end
				R_WAIT: begin
					if (rready) begin
						rvalid <= 1'b0;
						state <= R_BLIT;
					end
				end
				R_BLIT: begin
					// Zero nibble is transparent
					pix_wr <= (nibble != '0) && !cur_x[COORD_BITS];
					if (count == width) begin
						state <= R_NEXT;
					end else if (&count[1:0]) begin
						state <= R_LOAD_ADDR;
					end
				end
				R_NEXT: begin
					index <= index + 1'b1;
					if (index == SPRITE_IDX_BITS'(SPRITE_COUNT - 1)) begin
						state <= R_IDLE;
					end else begin
						state <= R_BEGIN;
					end
				end
				default: state <= R_IDLE;
			endcase
		end
	end

	// Sprite registers, fetch address and pixel data
	always_ff @(posedge CLK) begin
		case (state)
			R_LOAD_REGS: begin
				cur_x <= {1'b0, x_attr[X_POS_LSB +: X_POS_BITS]};
				palette <= x_attr[X_PAL_LSB +: X_PAL_BITS];
				wide <= x_attr[X_STRIDE_BIT];
				width <= y_attr[Y_WIDTH_LSB +: Y_WIDTH_BITS];
				row <= display_y - y_start;
				sheet_base <= addr_attr;
				count <= '0;
			end
			R_LOAD_ADDR: begin
				// count is a multiple of four here, so this is word aligned
				nib_addr <= {sheet_base, 2'b00} + row_offset + SHEET_ADDR_BITS'(count);
			end
			R_WAIT: begin
				if (rready) begin
					sheet_word <= memory_data;
				end
			end
			R_BLIT: begin
				pix_x <= cur_x[COORD_BITS-1:0];
				pix_color <= {palette, nibble};
				cur_x <= cur_x + 1'b1;
				count <= count + 1'b1;
			end
			default: ;
		endcase
	end

	// Request stays up with a fixed address until taken, unless a new line aborts it
	a_rvalid_hold: assert property (@(posedge CLK) disable iff (!RSTb)
		rvalid && !rready && !H_tick |=> rvalid && $stable(memory_address));

	a_pix_wr_blit: assert property (@(posedge CLK) disable iff (!RSTb)
		pix_wr |-> $past(state) == R_BLIT);

	a_state_legal: assert property (@(posedge CLK) disable iff (!RSTb)
		state inside {R_IDLE, R_BEGIN, R_LOAD_REGS, R_LOAD_ADDR,
			R_REQ, R_WAIT, R_BLIT, R_NEXT});

endmodule

// ==== src/video_pkg.sv ====
// Display line geometry shared by the renderer, the line buffer and the top level.
// Lines are 800 pixels; the line RAMs are 1024 deep and the upper entries are unused.
package video_pkg;

	// Visible pixels per line
	localparam int LINE_PIXELS = 800;

	// Width of display_x, display_y and sprite X/Y positions
	localparam int COORD_BITS = 10;

	// Colour index is four palette bits over one pixel nibble
	localparam int PIXEL_BITS = 8;

endpackage

// ==== verif/sprite_engine_tb.sv ====
// Sprite engine testbench with random sprites checked against a line model.
// A line period is 1200 clocks: 800 visible pixels, then blanking with display_x held
// at 799. A full walk with four 32-pixel sprites needs about 1090 clocks.
// Host writes are made between lines. The first two lines read buffer halves
// that were never cleared, so checking starts on line 2.
`timescale 1ns/10ps

module sprite_engine_tb;

	import sprite_pkg::*;
	import video_pkg::*;

	localparam int LINE_CLOCKS = 1200;
	localparam int DRIVE_DELAY = 2;
	localparam int SEED = 12161;
	localparam int MAX_WIDTH = 32;
	localparam int SHEET_WORDS = 65536;

	// Lines per test
	localparam int RESET_LINES = 4;
	localparam int SINGLE_RUNS = 6;
	localparam int SINGLE_LINES = 3;
	localparam int RANGE_RUNS = 2;
	localparam int RANGE_LINES = 5;
	localparam int OVERLAP_RUNS = 2;
	localparam int OVERLAP_LINES = 4;
	localparam int STALL_RUNS = 2;
	localparam int STALL_LINES = 4;
	localparam int EDGE_LINES = 3;
	localparam int CLEAR_LINES = 3;
	localparam int TOTAL_LINES = RESET_LINES + SINGLE_RUNS * SINGLE_LINES +
		RANGE_RUNS * RANGE_LINES + OVERLAP_RUNS * OVERLAP_LINES +
		STALL_RUNS * STALL_LINES + EDGE_LINES + CLEAR_LINES;
	// Lines, the attribute clear at start, and room for the host writes between lines
	localparam int TIMEOUT_CYCLES = TOTAL_LINES * LINE_CLOCKS + 4 * SPRITE_COUNT + 2000;

	logic CLK;
	logic RSTb;
	logic [9:0] ADDRESS;
	logic [15:0] DATA_IN;
	logic WR;
	logic H_tick;
	logic [COORD_BITS-1:0] display_x;
	logic [COORD_BITS-1:0] display_y;
	logic [PIXEL_BITS-1:0] color_index;
	logic [15:0] memory_address;
	logic [15:0] memory_data;
	logic rvalid;
	logic rready;

	logic [15:0] sheet [0:SHEET_WORDS-1];
	// Copy of every attribute word, by bank code
	logic [15:0] shadow [4][SPRITE_COUNT];
	logic [PIXEL_BITS-1:0] expected_next [LINE_PIXELS];
	logic [PIXEL_BITS-1:0] expected_shown [LINE_PIXELS];
	int used [$];
	string test_name = "none";
	int errors = 0;
	int mem_errors = 0;
	int cycle_count = 0;
	int line_count = 0;
	int request_count = 0;
	int stall_cycles = 0;

	tb_clock i_clock (
		.CLK(CLK),
		.RSTb(RSTb)
	);

	sprite_engine_top i_dut (
		.CLK(CLK),
		.RSTb(RSTb),
		.ADDRESS(ADDRESS),
		.DATA_IN(DATA_IN),
		.WR(WR),
		.H_tick(H_tick),
		.display_x(display_x),
		.display_y(display_y),
		.color_index(color_index),
		.memory_address(memory_address),
		.memory_data(memory_data),
		.rvalid(rvalid),
		.rready(rready)
	);

	always @(posedge CLK) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Errors found");
			$finish;
		end
	end

	// Memory responder with 0 to 3 cycles of delay before a one-cycle rready
	initial begin
		logic busy;
		int delay;
		logic [15:0] req_addr;
		busy = 1'b0;
		delay = 0;
		req_addr = '0;
		rready = 1'b0;
		memory_data = '0;
		forever begin
			@(posedge CLK);
			#DRIVE_DELAY;
			if (rready) begin
				// Word was taken at this edge
				rready = 1'b0;
				busy = 1'b0;
				if (rvalid) begin
					$display("%s: rvalid stayed high on the cycle after a handshake", test_name);
					mem_errors++;
				end
			end else if (rvalid) begin
				if (!busy) begin
					busy = 1'b1;
					req_addr = memory_address;
					delay = $urandom_range(0, 3);
					request_count++;
				end else begin
					stall_cycles++;
					if (memory_address !== req_addr) begin
						$display("Fail %s: memory_address while waiting, expected %h, actual %h",
							test_name, req_addr, memory_address);
						mem_errors++;
					end
				end
				if (delay == 0) begin
					rready = 1'b1;
					memory_data = sheet[req_addr];
				end else begin
					delay--;
				end
			end else if (busy) begin
				$display("%s: rvalid dropped before rready was given", test_name);
				mem_errors++;
				busy = 1'b0;
			end
		end
	end

	task automatic step();
		@(posedge CLK);
		#DRIVE_DELAY;
	endtask

	// One host write; the line loop drops WR again
	task automatic write_attr(input logic [1:0] bank, input int idx, input logic [15:0] value);
		step();
		ADDRESS = {bank, 8'(idx)};
		DATA_IN = value;
		WR = 1'b1;
		shadow[bank][idx] = value;
	endtask

	// Enabled sprite with random palette, stride and sheet address
	task automatic place_sprite(input int idx, input int x, input int y, input int rows,
		input int width);
		logic [15:0] xw;
		logic [15:0] yw;
		xw = '0;
		xw[X_POS_LSB +: X_POS_BITS] = 10'(x);
		xw[X_ENABLE_BIT] = 1'b1;
		xw[X_PAL_LSB +: X_PAL_BITS] = 4'($urandom);
		xw[X_STRIDE_BIT] = 1'($urandom);
		yw = '0;
		yw[Y_POS_LSB +: Y_POS_BITS] = 10'(y);
		yw[Y_WIDTH_LSB +: Y_WIDTH_BITS] = 6'(width - 1);
		write_attr(BANK_X, idx, xw);
		write_attr(BANK_Y, idx, yw);
		write_attr(BANK_END, idx, 16'(y + rows - 1));
		write_attr(BANK_ADDR, idx, 16'($urandom));
		used.push_back(idx);
	endtask

	task automatic disable_used();
		int idx;
		while (used.size() > 0) begin
			idx = used.pop_front();
			write_attr(BANK_X, idx, 16'h0000);
		end
	endtask

	// Reference line for display row y, built from the attribute copy
	task automatic build_expected(input int y);
		int i;
		int p;
		int first_row;
		int last_row;
		int width;
		int stride;
		int nib_addr;
		int col;
		logic [15:0] xw;
		logic [15:0] yw;
		logic [15:0] word;
		logic [3:0] nib;
		for (p = 0; p < LINE_PIXELS; p++) begin
			expected_next[p] = '0;
		end
		// Index order, so later sprites overwrite earlier ones
		for (i = 0; i < SPRITE_COUNT; i++) begin
			xw = shadow[BANK_X][i];
			yw = shadow[BANK_Y][i];
			first_row = yw[Y_POS_LSB +: Y_POS_BITS];
			last_row = shadow[BANK_END][i][END_ROW_LSB +: END_ROW_BITS];
			if (xw[X_ENABLE_BIT] && y >= first_row && y <= last_row) begin
				width = yw[Y_WIDTH_LSB +: Y_WIDTH_BITS] + 1;
				stride = xw[X_STRIDE_BIT] ? STRIDE_WIDE : STRIDE_NARROW;
				for (p = 0; p < width; p++) begin
					nib_addr = (shadow[BANK_ADDR][i] * 4 + (y - first_row) * stride + p)
						% (1 << 18);
					word = sheet[nib_addr / 4];
					nib = word[(nib_addr % 4) * 4 +: 4];
					col = xw[X_POS_LSB +: X_POS_BITS] + p;
					if (nib != 4'h0 && col < LINE_PIXELS) begin
						expected_next[col] = {xw[X_PAL_LSB +: X_PAL_BITS], nib};
					end
				end
			end
		end
	endtask

	// Each line shows what was rendered during the one before it
	task automatic run_lines(input int count);
		int n;
		int h;
		for (n = 0; n < count; n++) begin
			expected_shown = expected_next;
			build_expected(line_count);
			for (h = 0; h < LINE_CLOCKS; h++) begin
				step();
				// color_index now holds the pixel for the previous display_x
				if (line_count >= 2 && h >= 1 && h <= LINE_PIXELS) begin
					if (color_index !== expected_shown[h-1]) begin
						$display("Fail %s: line %0d pixel %0d, expected %h, actual %h",
							test_name, line_count, h - 1, expected_shown[h-1], color_index);
						errors++;
					end
				end
				WR = 1'b0;
				H_tick = (h == 0);
				display_x = (h < LINE_PIXELS) ? COORD_BITS'(h) : COORD_BITS'(LINE_PIXELS - 1);
				if (h == 0) begin
					display_y = COORD_BITS'(line_count);
				end
			end
			line_count++;
		end
	endtask

	initial begin
		int a;
		int k;
		int r;
		int idx;
		int base_x;
		int stalls_before;
		logic [15:0] word;
		ADDRESS = '0;
		DATA_IN = '0;
		WR = 1'b0;
		H_tick = 1'b0;
		display_x = '0;
		display_y = '0;
		void'($urandom(SEED));

		for (a = 0; a < SHEET_WORDS; a++) begin
			word = 16'($urandom);
			// About a quarter of the nibbles transparent
			for (k = 0; k < 4; k++) begin
				if ($urandom_range(0, 3) == 0) begin
					word[k*4 +: 4] = 4'h0;
				end
			end
			sheet[a] = word;
		end

		wait (RSTb === 1'b1);

		// Attribute RAMs power up unknown, so all banks start at zero
		for (a = 0; a < 4 * SPRITE_COUNT; a++) begin
			write_attr(2'(a / SPRITE_COUNT), a % SPRITE_COUNT, 16'h0000);
		end

		test_name = "reset";
		run_lines(RESET_LINES);
		if (request_count != 0) begin
			$display("%s: rvalid was raised %0d times with every sprite disabled",
				test_name, request_count);
			errors++;
		end

		test_name = "single_sprite";
		for (r = 0; r < SINGLE_RUNS; r++) begin
			place_sprite($urandom_range(0, SPRITE_COUNT - 1),
				$urandom_range(0, LINE_PIXELS - MAX_WIDTH), line_count, SINGLE_LINES,
				$urandom_range(1, MAX_WIDTH));
			run_lines(SINGLE_LINES);
			disable_used();
		end

		// Rows one inside the run at each end, so the first and last lines miss it
		test_name = "vertical_range";
		for (r = 0; r < RANGE_RUNS; r++) begin
			place_sprite($urandom_range(0, SPRITE_COUNT - 1),
				$urandom_range(0, LINE_PIXELS - MAX_WIDTH), line_count + 1, RANGE_LINES - 2,
				MAX_WIDTH);
			run_lines(RANGE_LINES);
			disable_used();
		end

		test_name = "overlap";
		for (r = 0; r < OVERLAP_RUNS; r++) begin
			base_x = $urandom_range(0, LINE_PIXELS - 2 * MAX_WIDTH);
			idx = 0;
			for (k = 0; k < 4; k++) begin
				idx = idx + $urandom_range(1, 60);
				place_sprite(idx, base_x + $urandom_range(0, MAX_WIDTH / 2), line_count,
					OVERLAP_LINES, $urandom_range(MAX_WIDTH / 2, MAX_WIDTH));
			end
			run_lines(OVERLAP_LINES);
			disable_used();
		end

		test_name = "back_pressure";
		stalls_before = stall_cycles;
		for (r = 0; r < STALL_RUNS; r++) begin
			idx = 0;
			for (k = 0; k < 3; k++) begin
				idx = idx + $urandom_range(1, 80);
				place_sprite(idx, $urandom_range(0, LINE_PIXELS - MAX_WIDTH), line_count,
					STALL_LINES, MAX_WIDTH);
			end
			run_lines(STALL_LINES);
			disable_used();
		end
		if (stall_cycles == stalls_before) begin
			$display("%s: rready was never held low during a request", test_name);
			errors++;
		end

		// One sprite across column 799 and one wholly past it
		test_name = "right_edge";
		place_sprite($urandom_range(0, 99), LINE_PIXELS - $urandom_range(1, MAX_WIDTH - 1),
			line_count, EDGE_LINES, MAX_WIDTH);
		place_sprite($urandom_range(100, SPRITE_COUNT - 1), 900, line_count, EDGE_LINES,
			MAX_WIDTH);
		run_lines(EDGE_LINES);

		test_name = "clear";
		disable_used();
		run_lines(CLEAR_LINES);

		$display("Run complete, error count %0d", errors + mem_errors);
		if (errors + mem_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== verif/tb_clock.sv ====
// Testbench clock and reset source. 20 ns period.
// RSTb is held low for the first four rising edges and released 2 ns after the fourth.
`timescale 1ns/10ps

module tb_clock (
	output logic CLK,
	output logic RSTb
);

	localparam int HALF_PERIOD = 10;
	localparam int RESET_CYCLES = 4;

	initial begin
		CLK = 1'b0;
		forever #HALF_PERIOD CLK = ~CLK;
	end

	initial begin
		RSTb = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#2;
		RSTb = 1'b1;
	end

endmodule

// ==== verilog.f ====
src/video_pkg.sv
src/sprite_pkg.sv
src/dual_port_ram.sv
src/sprite_attr_regs.sv
src/scanline_buffer.sv
src/sprite_renderer.sv
src/sprite_engine_top.sv
verif/tb_clock.sv
verif/sprite_engine_tb.sv
